//--- src/rv_pkg.sv
// --------------------
// rv_pkg
// shared encodings for the rv32i execute slice
// alu opcodes, major opcodes, operand selects
// --------------------
`default_nettype none

package rv_pkg;

    // register count fixed by the isa
    localparam int REG_COUNT = 32;

    // --------------------
    // alu operations
    // --------------------
    typedef enum logic [4:0] {
        ALU_AND  = 5'd0,
        ALU_OR   = 5'd1,
        ALU_XOR  = 5'd2,
        ALU_ADD  = 5'd3,
        ALU_SUB  = 5'd4,
        ALU_SLL  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SLT  = 5'd7,   // signed set less than
        ALU_SLTU = 5'd8,   // unsigned set less than
        ALU_SRA  = 5'd9,
        ALU_BEQ  = 5'd10,  // branch compares, cond only
        ALU_BNE  = 5'd11,
        ALU_BLT  = 5'd12,
        ALU_BLTU = 5'd13,
        ALU_BGE  = 5'd14,
        ALU_BGEU = 5'd15,
        ALU_LUI  = 5'd16   // operand b passes through
    } alu_op_e;

    // --------------------
    // rv32i major opcodes in use
    // --------------------
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // register/register alu
        OPC_OP_IMM = 7'b0010011,  // register/immediate alu
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // operand a source
    typedef enum logic {
        SRC_A_RS1 = 1'b0,
        SRC_A_PC  = 1'b1   // auipc
    } src_a_e;

    // operand b source
    typedef enum logic {
        SRC_B_RS2 = 1'b0,
        SRC_B_IMM = 1'b1
    } src_b_e;

endpackage

`default_nettype wire

//--- src/instr_decoder.sv
// --------------------
// instr_decoder
// rv32i decode for alu, lui, auipc and branches
// gives alu opcode, immediate, register fields,
// operand selects and write/branch/illegal flags
// --------------------
`timescale 1ns/10ps
`default_nettype none

module instr_decoder import rv_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  wire  [31:0]      i_instr,
    output alu_op_e          o_alu_op,
    output logic [WIDTH-1:0] o_imm,
    output logic [4:0]       o_rs1,
    output logic [4:0]       o_rs2,
    output logic [4:0]       o_rd,
    output src_a_e           o_src_a,
    output src_b_e           o_src_b,
    output logic             o_wr_en,
    output logic             o_is_branch,
    output logic             o_illegal
);

    opcode_e            opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic signed [31:0] imm_i;  // i-type, sign extended
    logic signed [31:0] imm_u;  // u-type, low 12 bits zero
    logic signed [31:0] imm_b;  // b-type, bit 0 zero

    // --------------------
    // instruction fields
    // --------------------
    assign opcode = opcode_e'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    assign o_rd   = i_instr[11:7];
    assign o_rs1  = i_instr[19:15];
    assign o_rs2  = i_instr[24:20];  // also shamt for immediate shifts

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                    i_instr[30:25], i_instr[11:8], 1'b0};

    always_comb begin
        // defaults describe an i-type add
        o_alu_op    = ALU_ADD;
        o_imm       = WIDTH'(imm_i);  // signed cast extends to WIDTH
        o_src_a     = SRC_A_RS1;
        o_src_b     = SRC_B_RS2;
        o_wr_en     = 1'b0;
        o_is_branch = 1'b0;
        o_illegal   = 1'b0;

        case (opcode)
            OPC_OP: begin
                o_wr_en = 1'b1;
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  o_alu_op = ALU_ADD;
                        3'b001:  o_alu_op = ALU_SLL;
                        3'b010:  o_alu_op = ALU_SLT;
                        3'b011:  o_alu_op = ALU_SLTU;
                        3'b100:  o_alu_op = ALU_XOR;
                        3'b101:  o_alu_op = ALU_SRL;
                        3'b110:  o_alu_op = ALU_OR;
                        default: o_alu_op = ALU_AND;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    o_alu_op = ALU_SUB;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
                    o_alu_op = ALU_SRA;
                end else begin
                    o_wr_en   = 1'b0;  // unknown funct7
                    o_illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                o_src_b = SRC_B_IMM;
                o_wr_en = 1'b1;
                case (funct3)
                    3'b000: o_alu_op = ALU_ADD;
                    3'b010: o_alu_op = ALU_SLT;
                    3'b011: o_alu_op = ALU_SLTU;
                    3'b100: o_alu_op = ALU_XOR;
                    3'b110: o_alu_op = ALU_OR;
                    3'b111: o_alu_op = ALU_AND;
                    3'b001: begin
                        o_alu_op  = ALU_SLL;
                        o_illegal = (funct7 != 7'b0000000);
                    end
                    default: begin  // 101, srli or srai by funct7
                        o_alu_op  = (funct7[5]) ? ALU_SRA : ALU_SRL;
                        o_illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    end
                endcase
                if (o_illegal) begin
                    o_wr_en = 1'b0;
                end
            end
            OPC_LUI: begin
                o_alu_op = ALU_LUI;
                o_imm    = WIDTH'(imm_u);
                o_src_b  = SRC_B_IMM;
                o_wr_en  = 1'b1;
            end
            OPC_AUIPC: begin
                o_imm   = WIDTH'(imm_u);  // pc + upper immediate on the alu adder
                o_src_a = SRC_A_PC;
                o_src_b = SRC_B_IMM;
                o_wr_en = 1'b1;
            end
            OPC_BRANCH: begin
                o_imm       = WIDTH'(imm_b);
                o_is_branch = 1'b1;  // no writeback
                case (funct3)
                    3'b000:  o_alu_op = ALU_BEQ;
                    3'b001:  o_alu_op = ALU_BNE;
                    3'b100:  o_alu_op = ALU_BLT;
                    3'b101:  o_alu_op = ALU_BGE;
                    3'b110:  o_alu_op = ALU_BLTU;
                    3'b111:  o_alu_op = ALU_BGEU;
                    default: o_illegal = 1'b1;  // 010 and 011 are reserved
                endcase
            end
            default: o_illegal = 1'b1;  // opcode outside the supported set
        endcase
    end

endmodule

`default_nettype wire

//--- src/reg_file.sv
// --------------------
// reg_file
// 32 entry integer register file
// two combinational reads, one synchronous write
// x0 is never written and reads zero
// --------------------
`timescale 1ns/10ps
`default_nettype none

module reg_file import rv_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  wire              i_clk,
    input  wire              i_rst,
    input  wire  [4:0]       i_rs1,
    input  wire  [4:0]       i_rs2,
    input  wire              i_wr_en,
    input  wire  [4:0]       i_wr_addr,
    input  wire  [WIDTH-1:0] i_wr_data,
    output logic [WIDTH-1:0] o_rd1,
    output logic [WIDTH-1:0] o_rd2
);

    logic [WIDTH-1:0] regs [REG_COUNT];

    // --------------------
    // write port
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;  // whole file clears
            end
        end else if (i_wr_en && (i_wr_addr != 5'd0)) begin
            regs[i_wr_addr] <= i_wr_data;  // writes to x0 dropped
        end
    end

    // read ports, no bypass, a write shows up after its edge
    assign o_rd1 = regs[i_rs1];
    assign o_rd2 = regs[i_rs2];

    // x0 keeps zero across every write sequence
    a_x0_zero: assert property (
        @(posedge i_clk) disable iff (i_rst)
        regs[0] == '0
    ) else $error("reg_file: x0 holds a nonzero value");

endmodule

`default_nettype wire

//--- src/alu.sv
// --------------------
// alu
// combinational rv32i alu
// logic, add/sub, shifts, set less than, branch compares, lui pass through
// o_cond carries the branch decision, or equality for slt/sltu
// --------------------
`timescale 1ns/10ps
`default_nettype none

module alu import rv_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  wire alu_op_e     i_alu_ctrl,
    input  wire  [WIDTH-1:0] i_rd1,        // operand a
    input  wire  [WIDTH-1:0] i_rd2,        // operand b
    output logic [WIDTH-1:0] o_alu_result,
    output logic             o_cond
);

    localparam int SHAMT_W = $clog2(WIDTH);  // 5 for rv32, 6 for 64 bit

    logic [WIDTH-1:0]   b_operand;
    logic               carry_in;
    logic [WIDTH-1:0]   sum;
    logic [SHAMT_W-1:0] shamt;
    logic               eq;
    logic               lt_s;
    logic               lt_u;

    // --------------------
    // shared adder
    // --------------------
    // sub is a + ~b + 1
    assign carry_in  = (i_alu_ctrl == ALU_SUB);
    assign b_operand = carry_in ? ~i_rd2 : i_rd2;
    assign sum       = i_rd1 + b_operand + WIDTH'(carry_in);

    // compare terms shared by slt and branches
    assign eq    = (i_rd1 == i_rd2);
    assign lt_s  = ($signed(i_rd1) < $signed(i_rd2));
    assign lt_u  = (i_rd1 < i_rd2);
    assign shamt = i_rd2[SHAMT_W-1:0];  // upper bits of b ignored

    // --------------------
    // result and condition
    // --------------------
    always_comb begin
        o_alu_result = '0;
        o_cond       = 1'b0;
        case (i_alu_ctrl)
            ALU_AND: o_alu_result = i_rd1 & i_rd2;
            ALU_OR:  o_alu_result = i_rd1 | i_rd2;
            ALU_XOR: o_alu_result = i_rd1 ^ i_rd2;
            ALU_ADD: o_alu_result = sum;
            ALU_SUB: o_alu_result = sum;
            ALU_SLL: o_alu_result = i_rd1 << shamt;
            ALU_SRL: o_alu_result = i_rd1 >> shamt;
            ALU_SRA: o_alu_result = $signed(i_rd1) >>> shamt;  // sign fills from the top
            ALU_SLT: begin
                o_alu_result = WIDTH'(lt_s);
                o_cond       = eq;
            end
            ALU_SLTU: begin
                o_alu_result = WIDTH'(lt_u);
                o_cond       = eq;
            end
            // branches leave the result at zero
            ALU_BEQ:  o_cond = eq;
            ALU_BNE:  o_cond = ~eq;
            ALU_BLT:  o_cond = lt_s;
            ALU_BLTU: o_cond = lt_u;
            ALU_BGE:  o_cond = ~lt_s;  // ge as not lt
            ALU_BGEU: o_cond = ~lt_u;
            ALU_LUI:  o_alu_result = i_rd2;  // immediate already shifted in decode
            default: begin
                o_alu_result = '0;  // unused codes give zero
                o_cond       = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/stage_execute.sv
// --------------------
// stage_execute
// operand select, branch target, branch decision
// one register stage for the results, drives the writeback port
// --------------------
`timescale 1ns/10ps
`default_nettype none

module stage_execute import rv_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  wire              i_clk,
    input  wire              i_rst,
    input  wire              i_valid,
    input  wire  [WIDTH-1:0] i_pc,
    input  wire  [WIDTH-1:0] i_rd1,         // rs1 read data
    input  wire  [WIDTH-1:0] i_rd2,         // rs2 read data
    input  wire  [WIDTH-1:0] i_imm,
    input  wire src_a_e      i_src_a,
    input  wire src_b_e      i_src_b,
    input  wire alu_op_e     i_alu_op,
    input  wire  [4:0]       i_rd,
    input  wire              i_wr_en,
    input  wire              i_is_branch,
    input  wire              i_illegal,
    input  wire  [WIDTH-1:0] i_alu_result,  // back from the alu
    input  wire              i_cond,
    output logic [WIDTH-1:0] o_op_a,
    output logic [WIDTH-1:0] o_op_b,
    output alu_op_e          o_alu_op,
    output logic             o_wb_en,
    output logic [4:0]       o_wb_addr,
    output logic [WIDTH-1:0] o_wb_data,
    output logic             o_valid,
    output logic [4:0]       o_rd,
    output logic [WIDTH-1:0] o_result,
    output logic             o_branch_taken,
    output logic [WIDTH-1:0] o_pc_target,
    output logic             o_illegal
);

    logic [WIDTH-1:0] pc_target;
    logic             taken;

    // --------------------
    // operands and branch
    // --------------------
    assign o_op_a   = (i_src_a == SRC_A_PC) ? i_pc : i_rd1;
    assign o_op_b   = (i_src_b == SRC_B_IMM) ? i_imm : i_rd2;
    assign o_alu_op = i_alu_op;

    assign pc_target = i_pc + i_imm;  // branch target, own adder
    assign taken     = i_valid & i_is_branch & i_cond & ~i_illegal;

    // writeback lands on the same edge as the output registers
    assign o_wb_en   = i_valid & i_wr_en & ~i_illegal;
    assign o_wb_addr = i_rd;
    assign o_wb_data = i_alu_result;

    // --------------------
    // output registers
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid        <= 1'b0;
            o_branch_taken <= 1'b0;
            o_illegal      <= 1'b0;
        end else begin
            o_valid        <= i_valid;  // one pulse per instruction
            o_branch_taken <= taken;
            o_illegal      <= i_valid & i_illegal;
        end
    end

    always_ff @(posedge i_clk) begin
        o_rd        <= i_rd;
        o_result    <= i_alu_result;
        o_pc_target <= pc_target;
    end

    a_taken_valid: assert property (@(posedge i_clk) disable iff (i_rst)
        o_branch_taken |-> o_valid) else $error("stage_execute: taken without valid");

    a_illegal_no_wb: assert property (@(posedge i_clk) disable iff (i_rst)
        o_illegal |-> $past(!o_wb_en)) else $error("stage_execute: illegal instr wrote back");

    a_valid_src: assert property (@(posedge i_clk) disable iff (i_rst)
        o_valid |-> $past(i_valid)) else $error("stage_execute: valid without input strobe");

endmodule

`default_nettype wire

//--- src/exec_top.sv
// --------------------
// exec_top
// rv32i execute slice
// decoder, register file, alu and execute register stage
// --------------------
`timescale 1ns/10ps
`default_nettype none

module exec_top import rv_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  wire              i_clk,
    input  wire              i_rst,
    input  wire              i_valid,
    input  wire  [31:0]      i_instr,
    input  wire  [WIDTH-1:0] i_pc,
    output logic             o_valid,
    output logic [4:0]       o_rd,
    output logic [WIDTH-1:0] o_result,
    output logic             o_branch_taken,
    output logic [WIDTH-1:0] o_pc_target,
    output logic             o_illegal
);

    // decode outputs
    alu_op_e          dec_alu_op;
    logic [WIDTH-1:0] dec_imm;
    logic [4:0]       dec_rs1;
    logic [4:0]       dec_rs2;
    logic [4:0]       dec_rd;
    src_a_e           dec_src_a;
    src_b_e           dec_src_b;
    logic             dec_wr_en;
    logic             dec_is_branch;
    logic             dec_illegal;

    // register file
    logic [WIDTH-1:0] rf_rd1;
    logic [WIDTH-1:0] rf_rd2;
    logic             wb_en;
    logic [4:0]       wb_addr;
    logic [WIDTH-1:0] wb_data;

    // alu side
    logic [WIDTH-1:0] alu_op_a;
    logic [WIDTH-1:0] alu_op_b;
    alu_op_e          alu_ctrl;
    logic [WIDTH-1:0] alu_result;
    logic             alu_cond;

    instr_decoder #(.WIDTH(WIDTH)) u_decoder (
        .i_instr(i_instr), .o_alu_op(dec_alu_op), .o_imm(dec_imm),
        .o_rs1(dec_rs1), .o_rs2(dec_rs2), .o_rd(dec_rd),
        .o_src_a(dec_src_a), .o_src_b(dec_src_b), .o_wr_en(dec_wr_en),
        .o_is_branch(dec_is_branch), .o_illegal(dec_illegal)
    );

    reg_file #(.WIDTH(WIDTH)) u_reg_file (
        .i_clk(i_clk), .i_rst(i_rst), .i_rs1(dec_rs1), .i_rs2(dec_rs2),
        .i_wr_en(wb_en), .i_wr_addr(wb_addr), .i_wr_data(wb_data),
        .o_rd1(rf_rd1), .o_rd2(rf_rd2)
    );

    alu #(.WIDTH(WIDTH)) u_alu (
        .i_alu_ctrl(alu_ctrl), .i_rd1(alu_op_a), .i_rd2(alu_op_b),
        .o_alu_result(alu_result), .o_cond(alu_cond)
    );

    stage_execute #(.WIDTH(WIDTH)) u_execute (
        .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_valid), .i_pc(i_pc),
        .i_rd1(rf_rd1), .i_rd2(rf_rd2), .i_imm(dec_imm),
        .i_src_a(dec_src_a), .i_src_b(dec_src_b), .i_alu_op(dec_alu_op),
        .i_rd(dec_rd), .i_wr_en(dec_wr_en), .i_is_branch(dec_is_branch),
        .i_illegal(dec_illegal), .i_alu_result(alu_result), .i_cond(alu_cond),
        .o_op_a(alu_op_a), .o_op_b(alu_op_b), .o_alu_op(alu_ctrl),
        .o_wb_en(wb_en), .o_wb_addr(wb_addr), .o_wb_data(wb_data),
        .o_valid(o_valid), .o_rd(o_rd), .o_result(o_result),
        .o_branch_taken(o_branch_taken), .o_pc_target(o_pc_target),
        .o_illegal(o_illegal)
    );

endmodule

`default_nettype wire

//--- test/tb_exec_top.sv
// --------------------
// tb_exec_top
// self-checking testbench for the rv32i execute slice
// encodes instructions, keeps a shadow register file and
// checks the registered outputs with concurrent assertions
// --------------------
`timescale 1ns/10ps
`default_nettype none

module tb_exec_top import rv_pkg::*; ();

    localparam int WIDTH       = 32;
    localparam int N_RAND      = 100;  // random ops, five instructions each
    localparam int N_DIRECTED  = 120;  // upper bound on directed instructions
    localparam int DRAIN       = 3;    // idle cycles closing each test
    localparam int WATCHDOG_NS = (N_RAND * 5 + N_DIRECTED + 8 + 6 * DRAIN + 200) * 20;

    // ops covered by the random test
    localparam alu_op_e ALU_OPS [10] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                                         ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU};
    // beq bne blt bge bltu bgeu
    localparam logic [2:0] BR_F3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

    logic        clk;
    logic        rst;
    logic        valid;
    logic [31:0] instr;
    logic [31:0] pc;

    logic        dut_valid;
    logic [4:0]  dut_rd;
    logic [31:0] dut_result;
    logic        dut_taken;
    logic [31:0] dut_target;
    logic        dut_illegal;

    // reference state
    logic [31:0] shadow [32];
    logic [31:0] cur_pc;
    int          seed;
    int          err_cnt;
    int          err_mark;
    int          tests_run;
    int          tests_ok;

    // expected outputs, pend_* set with the drive
    logic        pend_valid;
    logic [4:0]  pend_rd;
    logic [31:0] pend_result;
    logic        pend_br;
    logic        pend_taken;
    logic [31:0] pend_target;
    logic        pend_ill;

    // exp_* line up with the dut output registers
    logic        exp_valid;
    logic [4:0]  exp_rd;
    logic [31:0] exp_result;
    logic        exp_br;
    logic        exp_taken;
    logic [31:0] exp_target;
    logic        exp_ill;

    exec_top #(.WIDTH(WIDTH)) DUT (
        .i_clk(clk), .i_rst(rst), .i_valid(valid), .i_instr(instr), .i_pc(pc),
        .o_valid(dut_valid), .o_rd(dut_rd), .o_result(dut_result),
        .o_branch_taken(dut_taken), .o_pc_target(dut_target), .o_illegal(dut_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    always @(posedge clk) begin
        exp_valid  <= pend_valid;  // dut registers on this same edge
        exp_rd     <= pend_rd;
        exp_result <= pend_result;
        exp_br     <= pend_br;
        exp_taken  <= pend_taken;
        exp_target <= pend_target;
        exp_ill    <= pend_ill;
    end

    // --------------------
    // output checks
    // --------------------
    a_valid: assert property (@(posedge clk) disable iff (rst) dut_valid == exp_valid)
        else begin
            $display("MISMATCH %0t o_valid exp=%0b got=%0b", $time,
                     $sampled(exp_valid), $sampled(dut_valid));
            err_cnt++;
        end

    a_taken: assert property (@(posedge clk) disable iff (rst) dut_taken == exp_taken)
        else begin
            $display("MISMATCH %0t o_branch_taken exp=%0b got=%0b", $time,
                     $sampled(exp_taken), $sampled(dut_taken));
            err_cnt++;
        end

    a_illegal: assert property (@(posedge clk) disable iff (rst) dut_illegal == exp_ill)
        else begin
            $display("MISMATCH %0t o_illegal exp=%0b got=%0b", $time,
                     $sampled(exp_ill), $sampled(dut_illegal));
            err_cnt++;
        end

    a_rd: assert property (@(posedge clk) disable iff (rst) exp_valid |-> dut_rd == exp_rd)
        else begin
            $display("MISMATCH %0t o_rd exp=%0d got=%0d", $time,
                     $sampled(exp_rd), $sampled(dut_rd));
            err_cnt++;
        end

    // result is don't care for illegal words
    a_result: assert property (@(posedge clk) disable iff (rst)
        exp_valid && !exp_ill |-> dut_result == exp_result)
        else begin
            $display("MISMATCH %0t o_result exp=%08h got=%08h", $time,
                     $sampled(exp_result), $sampled(dut_result));
            err_cnt++;
        end

    a_target: assert property (@(posedge clk) disable iff (rst)
        exp_valid && exp_br |-> dut_target == exp_target)
        else begin
            $display("MISMATCH %0t o_pc_target exp=%08h got=%08h", $time,
                     $sampled(exp_target), $sampled(dut_target));
            err_cnt++;
        end

    // --------------------
    // reference rules
    // --------------------
    function automatic logic [31:0] ref_alu(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];  // rv32 shift amount
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return 32'($signed(a) >>> sh);
            ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'b0, a < b};
            default:  return 32'd0;
        endcase
    endfunction

    // {funct7 bit 5, funct3} per the isa tables
    function automatic logic [3:0] funct_of(input alu_op_e op);
        case (op)
            ALU_ADD:  return 4'b0000;
            ALU_SUB:  return 4'b1000;
            ALU_SLL:  return 4'b0001;
            ALU_SLT:  return 4'b0010;
            ALU_SLTU: return 4'b0011;
            ALU_XOR:  return 4'b0100;
            ALU_SRL:  return 4'b0101;
            ALU_SRA:  return 4'b1101;
            ALU_OR:   return 4'b0110;
            default:  return 4'b0111;  // and
        endcase
    endfunction

    function automatic logic cond_met(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;  // bgeu
        endcase
    endfunction

    // --------------------
    // drivers
    // --------------------
    task automatic send(input logic [31:0] word, input logic [31:0] res, input logic wr,
                        input logic br, input logic taken, input logic [31:0] target,
                        input logic ill);
        @(negedge clk);
        valid = 1'b1;
        instr = word;
        pc    = cur_pc;
        pend_valid  = 1'b1;
        pend_rd     = word[11:7];  // rd field is registered for every word
        pend_result = res;
        pend_br     = br;
        pend_taken  = taken;
        pend_target = target;
        pend_ill    = ill;
        if (wr && !ill && word[11:7] != 5'd0) begin
            shadow[word[11:7]] = res;  // dut writes at the coming edge
        end
        cur_pc = cur_pc + 32'd4;
    endtask

    task automatic idle();
        @(negedge clk);
        valid       = 1'b0;
        pend_valid  = 1'b0;
        pend_br     = 1'b0;
        pend_taken  = 1'b0;
        pend_ill    = 1'b0;
    endtask

    task automatic alu_rr(input alu_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2);
        logic [3:0] fn;
        fn = funct_of(op);
        send({fn[3] ? 7'b0100000 : 7'b0000000, rs2, rs1, fn[2:0], rd, OPC_OP},
             ref_alu(op, shadow[rs1], shadow[rs2]), 1'b1, 1'b0, 1'b0, 32'd0, 1'b0);
    endtask

    task automatic alu_ri(input alu_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
        logic [3:0]  fn;
        logic [11:0] field;
        fn    = funct_of(op);
        field = imm;
        if (op == ALU_SLL || op == ALU_SRL || op == ALU_SRA) begin
            field = {fn[3] ? 7'b0100000 : 7'b0000000, imm[4:0]};  // shamt form
        end
        send({field, rs1, fn[2:0], rd, OPC_OP_IMM},
             ref_alu(op, shadow[rs1], {{20{field[11]}}, field}),
             1'b1, 1'b0, 1'b0, 32'd0, 1'b0);
    endtask

    task automatic lui(input logic [4:0] rd, input logic [19:0] imm20);
        send({imm20, rd, OPC_LUI}, {imm20, 12'b0}, 1'b1, 1'b0, 1'b0, 32'd0, 1'b0);
    endtask

    task automatic auipc(input logic [4:0] rd, input logic [19:0] imm20);
        send({imm20, rd, OPC_AUIPC}, cur_pc + {imm20, 12'b0},
             1'b1, 1'b0, 1'b0, 32'd0, 1'b0);
    endtask

    task automatic branch(input logic [2:0] f3, input logic [4:0] rs1,
                          input logic [4:0] rs2, input logic [12:0] off);
        send({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH},
             32'd0, 1'b0, 1'b1, cond_met(f3, shadow[rs1], shadow[rs2]),
             cur_pc + {{19{off[12]}}, off}, 1'b0);
    endtask

    // full 32 bit value by lui then addi
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
        lui(rd, 20'((v + 32'h800) >> 12));
        alu_ri(ALU_ADD, rd, rd, v[11:0]);
    endtask

    task automatic begin_test();
        err_mark = err_cnt;
    endtask

    task automatic end_test(input string name);
        repeat (DRAIN) idle();  // let the last result reach its check
        tests_run++;
        if (err_cnt == err_mark) begin
            tests_ok++;
            $display("test %-8s ok", name);
        end else begin
            $display("test %-8s FAILED with %0d errors", name, err_cnt - err_mark);
        end
    endtask

    // --------------------
    // tests
    // --------------------
    task automatic test_random();
        alu_op_e    op;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        begin_test();
        for (int n = 0; n < N_RAND; n++) begin
            op  = ALU_OPS[{$random(seed)} % 10];
            rd  = 5'(1 + {$random(seed)} % 31);
            rs1 = 5'(1 + {$random(seed)} % 31);
            rs2 = 5'(1 + {$random(seed)} % 31);
            load_reg(rs1, $random(seed));  // negatives show up half the time
            load_reg(rs2, $random(seed));
            if (op != ALU_SUB && {$random(seed)} % 2 == 1) begin
                alu_ri(op, rd, rs1, 12'($random(seed)));
            end else begin
                alu_rr(op, rd, rs1, rs2);
            end
        end
        // shift amount corners and signed against unsigned compare
        load_reg(1, 32'h8000_0001);
        load_reg(2, 32'd31);
        alu_ri(ALU_SLL, 3, 1, 12'd0);
        alu_ri(ALU_SRL, 3, 1, 12'd31);
        alu_ri(ALU_SRA, 3, 1, 12'd31);
        alu_ri(ALU_SRA, 3, 1, 12'd0);
        alu_rr(ALU_SLL, 4, 1, 2);
        alu_rr(ALU_SRA, 4, 1, 2);
        alu_rr(ALU_SRL, 4, 1, 0);  // x0 as amount 0
        alu_rr(ALU_SLT, 5, 1, 2);
        alu_rr(ALU_SLTU, 5, 1, 2);
        alu_ri(ALU_SLTU, 5, 2, 12'hfff);  // imm sign extends, then unsigned
        end_test("random");
    endtask

    task automatic test_branches();
        begin_test();
        load_reg(1, 32'hffff_fffb);  // -5
        load_reg(2, 32'd7);
        load_reg(3, 32'd7);
        for (int k = 0; k < 6; k++) begin
            branch(BR_F3[k], 2, 3, 13'h1ff0);  // equal, back 16
            branch(BR_F3[k], 1, 2, 13'h0ffe);  // neg vs pos, far forward
            branch(BR_F3[k], 2, 1, 13'h0008);
        end
        alu_rr(ALU_OR, 20, 1, 0);  // registers kept their values
        alu_rr(ALU_OR, 21, 2, 0);
        alu_rr(ALU_OR, 22, 3, 0);
        end_test("branch");
    endtask

    task automatic test_x0_illegal();
        begin_test();
        load_reg(5, 32'h1357_9bdf);
        alu_ri(ALU_ADD, 0, 5, 12'h123);  // result shows, x0 stays zero
        lui(0, 20'habcde);
        alu_rr(ALU_OR, 6, 0, 0);
        load_reg(9, 32'h5a5a_3c3c);
        send({20'h12345, 5'd9, 7'b0000000}, 32'd0, 1'b0, 1'b0, 1'b0, 32'd0, 1'b1);
        send({7'b0000001, 5'd2, 5'd3, 3'b000, 5'd9, OPC_OP},  // m extension form
             32'd0, 1'b0, 1'b0, 1'b0, 32'd0, 1'b1);
        alu_ri(ALU_ADD, 10, 9, 12'd0);  // x9 unchanged
        end_test("x0_ill");
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        seed        = 32'hd34e_1a01;
        rst         = 1'b1;
        valid       = 1'b0;
        instr       = 32'd0;
        pc          = 32'd0;
        cur_pc      = 32'h0000_1000;
        pend_valid  = 1'b0;
        pend_rd     = 5'd0;
        pend_result = 32'd0;
        pend_br     = 1'b0;
        pend_taken  = 1'b0;
        pend_target = 32'd0;
        pend_ill    = 1'b0;
        err_cnt     = 0;
        err_mark    = 0;
        tests_run   = 0;
        tests_ok    = 0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = 32'd0;  // matches the cleared register file
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        begin_test();
        repeat (6) idle();  // outputs must stay quiet
        end_test("reset");

        begin_test();
        alu_ri(ALU_ADD, 1, 0, 12'd100);
        alu_ri(ALU_ADD, 2, 0, 12'hf9c);  // -100
        alu_ri(ALU_ADD, 3, 1, 12'h7ff);
        lui(4, 20'hdead0);
        lui(5, 20'h00001);
        alu_ri(ALU_ADD, 4, 4, 12'h5a5);
        auipc(6, 20'h00010);
        auipc(7, 20'hfffff);
        end_test("load");

        test_random();

        begin_test();
        alu_ri(ALU_ADD, 10, 0, 12'd1);
        for (int k = 0; k < 8; k++) begin
            alu_ri(ALU_ADD, 10, 10, 12'(k + 3));  // each reads the last write
        end
        alu_rr(ALU_ADD, 11, 10, 10);
        alu_rr(ALU_SUB, 12, 11, 10);
        alu_rr(ALU_XOR, 13, 12, 11);
        alu_ri(ALU_SLL, 14, 13, 12'd4);
        alu_rr(ALU_SLTU, 15, 14, 13);
        end_test("chain");

        test_branches();
        test_x0_illegal();

        $display("tests %0d, passed %0d, failed %0d, check errors %0d",
                 tests_run, tests_ok, tests_run - tests_ok, err_cnt);
        if (err_cnt == 0 && tests_ok == tests_run) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog sized from the instruction count
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
src/rv_pkg.sv
src/instr_decoder.sv
src/reg_file.sv
src/alu.sv
src/stage_execute.sv
src/exec_top.sv
test/tb_exec_top.sv

//--- Makefile
# Verilator build and run for the execute slice testbench
TOP = tb_exec_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	@if grep -q "Checks failed" sim.log; then echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
